/* src/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // Zero tag means the memory did not take the request
    localparam int TAG_BITS = 4;
    typedef logic [TAG_BITS-1:0] mem_tag_t;

    typedef enum logic [1:0] {
        mem_none = 2'd0,
        mem_load = 2'd1
    } mem_command_t;

    localparam int WORD_BITS = 32;
    localparam int BLOCK_WORDS = 2;

    // Stored as one doubleword, read by fetch as two instruction words
    typedef union packed {
        logic [BLOCK_WORDS*WORD_BITS-1:0] double_word;
        logic [BLOCK_WORDS-1:0][WORD_BITS-1:0] words;
    } mem_block_t;

    // Cache geometry, one block per line
    localparam int CACHE_LINES = 16;
    localparam int BLOCK_OFFSET_BITS = 3;
    localparam int CACHE_INDEX_BITS = $clog2(CACHE_LINES);
    localparam int CACHE_TAG_LSB = BLOCK_OFFSET_BITS + CACHE_INDEX_BITS;

    // Miss handler states
    localparam logic [1:0] MISS_IDLE = 2'd0;
    localparam logic [1:0] MISS_REQUEST = 2'd1;
    localparam logic [1:0] MISS_WAIT = 2'd2;

endpackage

`default_nettype wire

/* src/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    localparam int ADDR_BITS = 32;
    localparam int INST_BITS = 32;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [INST_BITS-1:0] inst_t;

    // Instructions per fetch group
    localparam int FETCH_WIDTH = 2;

    // Target buffer, indexed by PC bits above the word offset
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_INDEX_BITS = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_BITS = ADDR_BITS - BTB_INDEX_BITS - 2;

    // Matches the decode buffer depth
    localparam int FETCH_CREDITS = 8;
    localparam int CREDIT_BITS = $clog2(FETCH_CREDITS + 1);

    // addi x0, x0, 0
    localparam inst_t NOP = 32'h0000_0013;

endpackage

`default_nettype wire

/* src/branch_predictor.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_predictor (
    input  logic clock,
    input  logic reset,
    input  fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0] slot_pc,
    input  logic resolve_valid,
    input  fetch_pkg::addr_t resolve_pc,
    input  logic resolve_taken,
    input  fetch_pkg::addr_t resolve_target,
    output fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0] pred_target,
    output logic [fetch_pkg::FETCH_WIDTH-1:0] pred_taken
);

    logic btb_valid [fetch_pkg::BTB_ENTRIES];
    logic [fetch_pkg::BTB_TAG_BITS-1:0] btb_tag [fetch_pkg::BTB_ENTRIES];
    fetch_pkg::addr_t btb_target [fetch_pkg::BTB_ENTRIES];
    logic [1:0] btb_counter [fetch_pkg::BTB_ENTRIES];

    logic [fetch_pkg::BTB_INDEX_BITS-1:0] resolve_index;
    logic [fetch_pkg::BTB_TAG_BITS-1:0] resolve_tag;
    logic resolve_fresh;
    logic [1:0] base_counter;
    logic [1:0] next_counter;

    for (genvar i = 0; i < fetch_pkg::FETCH_WIDTH; i++) begin : g_lookup
        logic [fetch_pkg::BTB_INDEX_BITS-1:0] index;
        logic entry_hit;

        assign index = slot_pc[i][2 +: fetch_pkg::BTB_INDEX_BITS];
        assign entry_hit = btb_valid[index]
            && btb_tag[index] == slot_pc[i][fetch_pkg::ADDR_BITS-1 -: fetch_pkg::BTB_TAG_BITS];
        // Upper counter bit set means taken
        assign pred_taken[i] = entry_hit && btb_counter[index][1];
        assign pred_target[i] = pred_taken[i] ? btb_target[index] : slot_pc[i] + 32'd4;
    end

    assign resolve_index = resolve_pc[2 +: fetch_pkg::BTB_INDEX_BITS];
    assign resolve_tag = resolve_pc[fetch_pkg::ADDR_BITS-1 -: fetch_pkg::BTB_TAG_BITS];
    assign resolve_fresh = !btb_valid[resolve_index] || btb_tag[resolve_index] != resolve_tag;

    // Replaced entry restarts weakly not-taken before the update
    always_comb begin
        base_counter = resolve_fresh ? 2'b01 : btb_counter[resolve_index];
        if (resolve_taken) begin
            next_counter = (base_counter == 2'b11) ? 2'b11 : base_counter + 2'b01;
        end else begin
            next_counter = (base_counter == 2'b00) ? 2'b00 : base_counter - 2'b01;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < fetch_pkg::BTB_ENTRIES; i++) begin
                btb_valid[i] <= 1'b0;
                btb_counter[i] <= 2'b01;
            end
        end else if (resolve_valid) begin
            btb_valid[resolve_index] <= 1'b1;
            btb_counter[resolve_index] <= next_counter;
        end
    end

    always_ff @(posedge clock) begin
        if (resolve_valid) begin
            btb_tag[resolve_index] <= resolve_tag;
            btb_target[resolve_index] <= resolve_target;
        end
    end

    // A taken resolve never leaves the counter at zero, a not-taken one never at three
    counter_range: assert property (@(posedge clock) disable iff (reset)
        resolve_valid |=> btb_counter[$past(resolve_index)]
            != ($past(resolve_taken) ? 2'b00 : 2'b11));

endmodule

`default_nettype wire

/* src/instr_cache.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_cache (
    input  logic clock,
    input  logic reset,
    input  logic squash,
    input  fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0] slot_pc,
    output logic [fetch_pkg::FETCH_WIDTH-1:0] hit,
    output mem_pkg::mem_block_t [fetch_pkg::FETCH_WIDTH-1:0] block,
    output mem_pkg::mem_command_t mem_command,
    output fetch_pkg::addr_t mem_addr,
    input  mem_pkg::mem_tag_t mem_transaction_tag,
    input  mem_pkg::mem_block_t mem_data,
    input  mem_pkg::mem_tag_t mem_data_tag
);

    logic line_valid [mem_pkg::CACHE_LINES];
    logic [fetch_pkg::ADDR_BITS-1:mem_pkg::CACHE_TAG_LSB] line_tag [mem_pkg::CACHE_LINES];
    mem_pkg::mem_block_t line_data [mem_pkg::CACHE_LINES];

    logic [1:0] miss_state;
    fetch_pkg::addr_t miss_addr;
    mem_pkg::mem_tag_t pending_tag;
    fetch_pkg::addr_t miss_pc;
    logic [mem_pkg::CACHE_INDEX_BITS-1:0] fill_index;
    logic miss_start;
    logic fill;

    for (genvar i = 0; i < fetch_pkg::FETCH_WIDTH; i++) begin : g_read
        logic [mem_pkg::CACHE_INDEX_BITS-1:0] index;

        assign index = slot_pc[i][mem_pkg::BLOCK_OFFSET_BITS +: mem_pkg::CACHE_INDEX_BITS];
        assign hit[i] = line_valid[index]
            && line_tag[index] == slot_pc[i][fetch_pkg::ADDR_BITS-1:mem_pkg::CACHE_TAG_LSB];
        assign block[i] = line_data[index];
    end

    // Slot 0 has priority for the single miss handler
    assign miss_pc = hit[0] ? slot_pc[1] : slot_pc[0];
    assign miss_start = miss_state == mem_pkg::MISS_IDLE && !(&hit);

    // pending_tag is zero whenever no load is outstanding
    assign fill = pending_tag != '0 && mem_data_tag == pending_tag && !squash;
    assign fill_index = miss_addr[mem_pkg::BLOCK_OFFSET_BITS +: mem_pkg::CACHE_INDEX_BITS];

    assign mem_command = (miss_state == mem_pkg::MISS_REQUEST && !squash)
        ? mem_pkg::mem_load : mem_pkg::mem_none;
    assign mem_addr = miss_addr;

    always_ff @(posedge clock) begin
        if (reset) begin
            miss_state <= mem_pkg::MISS_IDLE;
            pending_tag <= '0;
        end else if (squash) begin
            // Drop the outstanding load, its data is ignored
            miss_state <= mem_pkg::MISS_IDLE;
            pending_tag <= '0;
        end else begin
            case (miss_state)
                mem_pkg::MISS_IDLE: begin
                    if (miss_start) begin
                        miss_state <= mem_pkg::MISS_REQUEST;
                    end
                end
                mem_pkg::MISS_REQUEST: begin
                    if (mem_transaction_tag != '0) begin
                        miss_state <= mem_pkg::MISS_WAIT;
                        pending_tag <= mem_transaction_tag;
                    end
                end
                mem_pkg::MISS_WAIT: begin
                    if (fill) begin
                        miss_state <= mem_pkg::MISS_IDLE;
                        pending_tag <= '0;
                    end
                end
                default: miss_state <= mem_pkg::MISS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < mem_pkg::CACHE_LINES; i++) begin
                line_valid[i] <= 1'b0;
            end
        end else if (fill) begin
            line_valid[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (miss_start) begin
            miss_addr <= {miss_pc[fetch_pkg::ADDR_BITS-1:mem_pkg::BLOCK_OFFSET_BITS],
                          {mem_pkg::BLOCK_OFFSET_BITS{1'b0}}};
        end
        if (fill) begin
            line_tag[fill_index] <= miss_addr[fetch_pkg::ADDR_BITS-1:mem_pkg::CACHE_TAG_LSB];
            line_data[fill_index].double_word <= mem_data.double_word;
        end
    end

    load_aligned: assert property (@(posedge clock) disable iff (reset)
        mem_command == mem_pkg::mem_load
            |-> mem_addr[mem_pkg::BLOCK_OFFSET_BITS-1:0] == '0);

    no_idle_fill: assert property (@(posedge clock) disable iff (reset)
        fill |-> miss_state != mem_pkg::MISS_IDLE);

endmodule

`default_nettype wire

/* src/fetch_control.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_control (
    input  logic clock,
    input  logic reset,
    input  logic resolve_mispredict,
    input  fetch_pkg::addr_t resolve_target,
    input  fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0] pred_target,
    input  logic [fetch_pkg::FETCH_WIDTH-1:0] pred_taken,
    input  logic [fetch_pkg::FETCH_WIDTH-1:0] hit,
    input  mem_pkg::mem_block_t [fetch_pkg::FETCH_WIDTH-1:0] block,
    input  logic [1:0] credit_return,
    output fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0] slot_pc,
    output logic squash,
    output logic group_valid,
    output logic [fetch_pkg::FETCH_WIDTH-1:0] slot_valid,
    output fetch_pkg::inst_t [fetch_pkg::FETCH_WIDTH-1:0] slot_inst,
    output logic [fetch_pkg::FETCH_WIDTH-1:0] slot_predict_taken,
    output fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0] slot_predict_target
);

    fetch_pkg::addr_t pc;
    fetch_pkg::addr_t next_pc;
    logic [fetch_pkg::FETCH_WIDTH-1:0] slot_ready;
    logic [fetch_pkg::CREDIT_BITS-1:0] credits;
    logic [fetch_pkg::CREDIT_BITS-1:0] credits_spent;
    logic has_credits;

    assign squash = resolve_mispredict;

    // Each later slot follows the predicted path of the one before
    assign slot_pc[0] = pc;
    for (genvar i = 1; i < fetch_pkg::FETCH_WIDTH; i++) begin : g_slot_pc
        assign slot_pc[i] = pred_target[i-1];
    end

    always_comb begin
        slot_ready[0] = hit[0];
        for (int i = 1; i < fetch_pkg::FETCH_WIDTH; i++) begin
            slot_ready[i] = slot_ready[i-1] && hit[i];
        end

        // A full group's worth of credits is needed to issue
        has_credits = credits >= fetch_pkg::FETCH_WIDTH;
        group_valid = slot_ready[0] && has_credits && !squash;

        credits_spent = '0;
        next_pc = pc;
        for (int i = 0; i < fetch_pkg::FETCH_WIDTH; i++) begin
            slot_valid[i] = slot_ready[i] && group_valid;
            slot_inst[i] = slot_valid[i] ? block[i].words[slot_pc[i][2]] : fetch_pkg::NOP;
            slot_predict_taken[i] = slot_valid[i] && pred_taken[i];
            slot_predict_target[i] = pred_target[i];
            if (slot_valid[i]) begin
                credits_spent = credits_spent + 1'b1;
                next_pc = pred_target[i];
            end
        end

        // Mispredict beats both advance and hold
        if (squash) begin
            next_pc = resolve_target;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
            credits <= fetch_pkg::CREDIT_BITS'(fetch_pkg::FETCH_CREDITS);
        end else begin
            pc <= next_pc;
            credits <= credits - credits_spent + fetch_pkg::CREDIT_BITS'(credit_return);
        end
    end

    // Decode must never return more than it was given
    credit_bound: assert property (@(posedge clock) disable iff (reset)
        credits <= fetch_pkg::FETCH_CREDITS);

endmodule

`default_nettype wire

/* src/fetch_top.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_top (
    input  logic clock,
    input  logic reset,
    input  logic resolve_valid,
    input  fetch_pkg::addr_t resolve_pc,
    input  logic resolve_taken,
    input  fetch_pkg::addr_t resolve_target,
    input  logic resolve_mispredict,
    input  logic [1:0] credit_return,
    input  mem_pkg::mem_tag_t mem_transaction_tag,
    input  mem_pkg::mem_block_t mem_data,
    input  mem_pkg::mem_tag_t mem_data_tag,
    output mem_pkg::mem_command_t mem_command,
    output fetch_pkg::addr_t mem_addr,
    output fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0] slot_pc,
    output logic group_valid,
    output logic [fetch_pkg::FETCH_WIDTH-1:0] slot_valid,
    output fetch_pkg::inst_t [fetch_pkg::FETCH_WIDTH-1:0] slot_inst,
    output logic [fetch_pkg::FETCH_WIDTH-1:0] slot_predict_taken,
    output fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0] slot_predict_target
);

    logic squash;
    fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0] pred_target;
    logic [fetch_pkg::FETCH_WIDTH-1:0] pred_taken;
    logic [fetch_pkg::FETCH_WIDTH-1:0] hit;
    mem_pkg::mem_block_t [fetch_pkg::FETCH_WIDTH-1:0] block;

    branch_predictor predictor (.*);

    instr_cache cache (.*);

    fetch_control control (.*);

endmodule

`default_nettype wire

/* verification/fetch_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_tb;

    localparam int MIN_LATENCY = 2;
    localparam int MAX_LATENCY = 6;
    // Cycles the five tests take when every fetch hits
    localparam int TEST_CYCLES = 160;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES * 2 * MAX_LATENCY;

    logic clock;
    logic reset = 1'b1;
    logic resolve_valid;
    fetch_pkg::addr_t resolve_pc;
    logic resolve_taken;
    fetch_pkg::addr_t resolve_target;
    logic resolve_mispredict;
    logic [1:0] credit_return;
    mem_pkg::mem_tag_t mem_transaction_tag;
    mem_pkg::mem_block_t mem_data;
    mem_pkg::mem_tag_t mem_data_tag;
    mem_pkg::mem_command_t mem_command;
    fetch_pkg::addr_t mem_addr;
    fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0] slot_pc;
    logic group_valid;
    logic [fetch_pkg::FETCH_WIDTH-1:0] slot_valid;
    fetch_pkg::inst_t [fetch_pkg::FETCH_WIDTH-1:0] slot_inst;
    logic [fetch_pkg::FETCH_WIDTH-1:0] slot_predict_taken;
    fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0] slot_predict_target;

    // Program image in words 0 to 63, then the test records
    fetch_pkg::inst_t testdata [0:67];
    fetch_pkg::addr_t issued_pc [$];
    logic issued_taken [$];
    fetch_pkg::addr_t issued_target [$];
    fetch_pkg::addr_t req_addr [$];
    mem_pkg::mem_tag_t req_tag [$];
    int req_due [$];
    int load_count [fetch_pkg::addr_t];
    bit filled [fetch_pkg::addr_t];
    int cycle_count = 0;
    int issued_total = 0;
    int returned_total = 0;
    int error_count = 0;
    int failed_tests = 0;
    bit credit_hold = 1'b0;

    fetch_top dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic fetch_pkg::inst_t image_word(input fetch_pkg::addr_t addr);
        return testdata[addr[7:2]];
    endfunction

    function automatic int loads_at(input fetch_pkg::addr_t addr);
        return load_count.exists(addr) ? load_count[addr] : 0;
    endfunction

    task automatic check_inst(input string name, input fetch_pkg::inst_t got,
                              input fetch_pkg::inst_t expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_pc(input string name, input fetch_pkg::addr_t got,
                            input fetch_pkg::addr_t expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input bit got, input bit expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_sequence(input fetch_pkg::addr_t start, input int count);
        for (int k = 0; k < count; k++) begin
            check_pc($sformatf("issued_pc[%0d]", k), issued_pc[k], start + 4 * k);
        end
    endtask

    task automatic wait_issued(input int count);
        while (issued_pc.size() < count) @(posedge clock);
    endtask

    // One-cycle mispredict, the group of that cycle must be squashed
    task automatic send_resolve(input logic valid, input fetch_pkg::addr_t pc,
                                input logic taken, input fetch_pkg::addr_t target);
        @(posedge clock);
        #1;
        issued_pc.delete();
        issued_taken.delete();
        issued_target.delete();
        resolve_valid = valid;
        resolve_pc = pc;
        resolve_taken = taken;
        resolve_target = target;
        resolve_mispredict = 1'b1;
        @(negedge clock);
        check_flag("group_valid", group_valid, 1'b0);
        @(posedge clock);
        #1;
        resolve_valid = 1'b0;
        resolve_mispredict = 1'b0;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // Memory offers the next tag every cycle, a load takes it
    initial begin
        mem_pkg::mem_block_t data;
        bit accepted;
        accepted = 1'b0;
        @(negedge reset);
        forever begin
            @(posedge clock);
            #1;
            if (accepted) begin
                mem_transaction_tag = (mem_transaction_tag == '1) ? 4'd1
                    : mem_transaction_tag + 4'd1;
            end
            mem_data_tag = '0;
            if (req_tag.size() > 0 && req_due[0] <= cycle_count) begin
                data.words[0] = image_word(req_addr[0]);
                data.words[1] = image_word(req_addr[0] + 4);
                mem_data = data;
                mem_data_tag = req_tag[0];
                filled[req_addr[0]] = 1'b1;
                void'(req_addr.pop_front());
                void'(req_tag.pop_front());
                void'(req_due.pop_front());
            end
            @(negedge clock);
            accepted = mem_command == mem_pkg::mem_load;
            if (accepted) begin
                req_addr.push_back(mem_addr);
                req_tag.push_back(mem_transaction_tag);
                req_due.push_back(cycle_count + 1 + $urandom_range(MAX_LATENCY, MIN_LATENCY));
                load_count[mem_addr] = loads_at(mem_addr) + 1;
            end
        end
    end

    // Decode side, frees at most what it holds
    initial begin
        int give;
        @(negedge reset);
        forever begin
            @(posedge clock);
            #1;
            give = 0;
            if (!credit_hold) begin
                give = $urandom_range(2, 0);
                if (give > issued_total - returned_total) begin
                    give = issued_total - returned_total;
                end
            end
            credit_return = 2'(give);
            returned_total += give;
        end
    end

    always @(negedge clock) begin
        if (!reset && group_valid) begin
            for (int i = 0; i < fetch_pkg::FETCH_WIDTH; i++) begin
                if (slot_valid[i]) begin
                    check_inst($sformatf("slot_inst[%0d]", i), slot_inst[i],
                               image_word(slot_pc[i]));
                    check_flag($sformatf("block_filled[%0d]", i),
                               filled.exists({slot_pc[i][31:3], 3'b000}) != 0, 1'b1);
                    issued_pc.push_back(slot_pc[i]);
                    issued_taken.push_back(slot_predict_taken[i]);
                    issued_target.push_back(slot_predict_target[i]);
                    issued_total++;
                end else begin
                    check_inst($sformatf("slot_inst[%0d]", i), slot_inst[i], fetch_pkg::NOP);
                end
            end
            if (issued_total > fetch_pkg::FETCH_CREDITS + returned_total) begin
                $display("credit overrun: %0d instructions issued against %0d credits",
                         issued_total, fetch_pkg::FETCH_CREDITS + returned_total);
                error_count++;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int errors_before;
        int stall_size;
        fetch_pkg::addr_t branch_pc;
        fetch_pkg::addr_t branch_target;
        void'($urandom(21021));
        $readmemh("verification/fetch_testdata.hex", testdata);
        resolve_valid = 1'b0;
        resolve_pc = '0;
        resolve_taken = 1'b0;
        resolve_target = '0;
        resolve_mispredict = 1'b0;
        credit_return = '0;
        mem_transaction_tag = 4'd1;
        mem_data = '0;
        mem_data_tag = '0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        errors_before = error_count;
        wait_issued(16);
        check_sequence(32'h0, 16);
        finish_test("sequential_fetch", errors_before);

        // Same blocks again, all from the cache
        errors_before = error_count;
        send_resolve(1'b0, '0, 1'b0, 32'h0);
        wait_issued(16);
        check_sequence(32'h0, 16);
        for (int a = 0; a < 'h40; a += 8) begin
            check_flag($sformatf("single_load_%h", a), loads_at(a) == 1, 1'b1);
        end
        finish_test("miss_and_fill", errors_before);

        errors_before = error_count;
        for (int j = 0; j < 2; j++) begin
            send_resolve(1'b0, '0, 1'b0, testdata[64 + j]);
            wait_issued(4);
            check_sequence(testdata[64 + j], 4);
        end
        finish_test("redirect", errors_before);

        errors_before = error_count;
        branch_pc = testdata[66];
        branch_target = testdata[67];
        send_resolve(1'b1, branch_pc, 1'b1, branch_target);
        wait_issued(1);
        check_pc("issued_pc[0]", issued_pc[0], branch_target);
        send_resolve(1'b0, '0, 1'b0, branch_pc - 16);
        wait_issued(6);
        check_sequence(branch_pc - 16, 5);
        check_flag("slot_predict_taken", issued_taken[4], 1'b1);
        check_pc("slot_predict_target", issued_target[4], branch_target);
        check_pc("issued_pc[5]", issued_pc[5], branch_target);
        finish_test("prediction_learning", errors_before);

        errors_before = error_count;
        @(negedge clock);
        credit_hold = 1'b1;
        send_resolve(1'b0, '0, 1'b0, 32'h80);
        while (issued_total - returned_total < fetch_pkg::FETCH_CREDITS - 1) @(posedge clock);
        stall_size = issued_pc.size();
        repeat (8) begin
            @(negedge clock);
            check_flag("group_valid", group_valid, 1'b0);
        end
        credit_hold = 1'b0;
        wait_issued(stall_size + 6);
        check_sequence(32'h80, stall_size + 6);
        finish_test("credit_backpressure", errors_before);

        $display("5 tests run, %0d failed, %0d check errors", failed_tests, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/fetch_testdata.hex */
// Words 0 to 63: program image, word n sits at byte address 4n
// Then: redirect target 0, redirect target 1, branch pc, branch target
00000093 00100093 00200093 00300093
00400093 00500093 00600093 00700093
00800093 00900093 00a00093 00b00093
00c00093 00d00093 00e00093 00f00093
01000093 01100093 01200093 01300093
01400093 01500093 01600093 01700093
01800093 01900093 01a00093 01b00093
01c00093 01d00093 01e00093 01f00093
02000093 02100093 02200093 02300093
02400093 02500093 02600093 02700093
02800093 02900093 02a00093 02b00093
02c00093 02d00093 02e00093 02f00093
03000093 03100093 03200093 03300093
03400093 03500093 03600093 03700093
03800093 03900093 03a00093 03b00093
03c00093 03d00093 03e00093 03f00093
00000094 0000002c
00000070 00000020

/* all.f */
src/mem_pkg.sv
src/fetch_pkg.sv
src/branch_predictor.sv
src/instr_cache.sv
src/fetch_control.sv
src/fetch_top.sv
verification/fetch_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f all.f
	./obj_dir/Vfetch_tb | tee /dev/stderr | grep -x "ALL TESTS PASSED" > /dev/null

clean:
	rm -rf obj_dir
